// ==== files.f ====
verilog/lsu_pkg.sv
verilog/ls_queue.sv
verilog/data_cache.sv
verilog/load_align.sv
verilog/lsu_top.sv
verification/mem_model.sv
verification/lsu_properties.sv
verification/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/lsu_tb.sv ====
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int QUEUE_DEPTH = 8;
  localparam int CACHE_LINES = 16;
  localparam int CLK_PERIOD = 4;
  localparam int NUM_TESTS = 5;
  localparam int TEST_CYCLES = 400;

  logic     clk = 1'b0;
  logic     rst;
  issue_t   issue;
  logic     full;
  cdb_t     rs_cdb;
  logic     commit_store;
  logic     flush;
  mem_req_t mem_req;
  logic     mem_ready;
  line_t    mem_rdata;
  io_req_t  io_req;
  logic     io_ready;
  byte_t    io_rdata;
  cdb_t     ls_cdb;

  int    mem_reads;
  int    mem_writes;
  int    io_writes;
  word_t last_wr_addr;
  line_t last_wr_line;
  word_t last_io_addr;
  byte_t last_io_data;

  // expected memory contents after committed stores
  byte_t   shadow [word_t];
  rob_id_t got_order [$];
  word_t   got_value [$];
  rob_id_t exp_order [$];
  word_t   exp_value [$];
  logic [15:0] flushed_tags = '0;
  string   test_name = "";
  int      tests_run = 0;
  int      errors = 0;
  int      test_errors = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  lsu_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .CACHE_LINES(CACHE_LINES)
  ) lsu_top_i (
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .full(full),
    .rs_cdb(rs_cdb),
    .commit_store(commit_store),
    .flush(flush),
    .mem_req(mem_req),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .io_req(io_req),
    .io_ready(io_ready),
    .io_rdata(io_rdata),
    .ls_cdb(ls_cdb)
  );

  mem_model mem_model_i (
    .clk(clk),
    .mem_req(mem_req),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .io_req(io_req),
    .io_ready(io_ready),
    .io_rdata(io_rdata),
    .mem_reads(mem_reads),
    .mem_writes(mem_writes),
    .io_writes(io_writes),
    .last_wr_addr(last_wr_addr),
    .last_wr_line(last_wr_line),
    .last_io_addr(last_io_addr),
    .last_io_data(last_io_data)
  );

  function automatic byte_t mem_byte(input word_t addr);
    if (addr >= IO_BASE) return 8'h80 + byte_t'(addr[3:0]);
    if (shadow.exists(addr)) return shadow[addr];
    return addr[7:0] ^ 8'h5a;
  endfunction

  // n bytes little-endian, the bytes above filled with the sign or with zero
  function automatic word_t load_expect(input ls_op_t op, input word_t addr);
    word_t w;
    int    n;
    byte_t msb_byte;
    logic  fill_bit;
    n = (op == OP_LB || op == OP_LBU) ? 1 : (op == OP_LH || op == OP_LHU) ? 2 : 4;
    msb_byte = mem_byte(addr + word_t'(n - 1));
    fill_bit = (op == OP_LB || op == OP_LH) && msb_byte[7];
    for (int k = 0; k < 4; k++) begin
      w[k*8 +: 8] = (k < n) ? mem_byte(addr + word_t'(k)) : {8{fill_bit}};
    end
    return w;
  endfunction

  task automatic check_value(input string what, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
    test_errors++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // drives one micro-op; a broadcast set up by the caller lasts the same cycle
  task automatic send_op(input ls_op_t op, input rob_id_t dest, input rob_id_t qj,
                         input word_t vj, input rob_id_t qk, input word_t vk,
                         input word_t imm);
    while (full) idle_cycles(1);
    issue = '{valid: 1'b1, op: op, dest: dest, qj: qj, vj: vj, qk: qk, vk: vk, imm: imm};
    idle_cycles(1);
    issue.valid = 1'b0;
    rs_cdb.valid = 1'b0;
  endtask

  task automatic issue_load(input ls_op_t op, input rob_id_t dest, input word_t base,
                            input word_t imm);
    exp_order.push_back(dest);
    exp_value.push_back(load_expect(op, base + imm));
    send_op(op, dest, '0, base, '0, '0, imm);
  endtask

  task automatic issue_store(input ls_op_t op, input rob_id_t dest, input word_t addr,
                             input word_t data);
    int n;
    n = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
    for (int k = 0; k < n; k++) begin
      shadow[addr + word_t'(k)] = data[k*8 +: 8];
    end
    send_op(op, dest, '0, addr, '0, data, '0);
  endtask

  task automatic broadcast(input rob_id_t tag, input word_t value);
    rs_cdb = '{valid: 1'b1, tag: tag, value: value};
    idle_cycles(1);
    rs_cdb.valid = 1'b0;
  endtask

  task automatic pulse_commit();
    commit_store = 1'b1;
    idle_cycles(1);
    commit_store = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
    tests_run++;
    got_order.delete();
    got_value.delete();
    exp_order.delete();
    exp_value.delete();
  endtask

  // waits for every expected result, then a few cycles for strays
  task automatic collect_results();
    while (got_order.size() < exp_order.size()) idle_cycles(1);
    idle_cycles(8);
    check_value("result count", word_t'(exp_order.size()), word_t'(got_order.size()));
    for (int i = 0; i < exp_order.size() && i < got_order.size(); i++) begin
      check_value($sformatf("tag #%0d", i), word_t'(exp_order[i]), word_t'(got_order[i]));
      check_value($sformatf("value of tag %0d", exp_order[i]), exp_value[i], got_value[i]);
    end
  endtask

  task automatic report_test();
    $display("test %s: %0d errors", test_name, test_errors);
  endtask

  always @(negedge clk) begin
    if (!rst && ls_cdb.valid) begin
      got_order.push_back(ls_cdb.tag);
      got_value.push_back(ls_cdb.value);
      if (flushed_tags[ls_cdb.tag]) begin
        report_failure($sformatf("flushed tag %0d was broadcast", ls_cdb.tag));
      end
    end
  end

  task automatic load_widths();
    start_test("load_widths");
    // first load misses, the rest hit the same line
    issue_load(OP_LW, 4'd1, 32'h1080, 32'd0);
    issue_load(OP_LB, 4'd2, 32'h1080, 32'd3);
    issue_load(OP_LBU, 4'd3, 32'h1080, 32'd3);
    issue_load(OP_LH, 4'd4, 32'h1080, 32'd6);
    issue_load(OP_LHU, 4'd5, 32'h1080, 32'd6);
    issue_load(OP_LW, 4'd6, 32'h1080, 32'd12);
    collect_results();
    report_test();
  endtask

  task automatic operand_wakeup();
    word_t first;
    start_test("operand_wakeup");
    first = load_expect(OP_LBU, 32'h20da);
    exp_order.push_back(4'd1);
    exp_order.push_back(4'd2);
    exp_order.push_back(4'd3);
    exp_value.push_back(first);
    exp_value.push_back(load_expect(OP_LW, first + 32'h2400));
    exp_value.push_back(load_expect(OP_LW, 32'h2104));
    send_op(OP_LBU, 4'd1, 4'd9, '0, '0, '0, 32'h00da);
    // base comes from the first load's result
    send_op(OP_LW, 4'd2, 4'd1, '0, '0, '0, 32'h2400);
    idle_cycles(10);
    check_value("results before wakeup", '0, word_t'(got_order.size()));
    // tag broadcast in the issue cycle itself
    rs_cdb = '{valid: 1'b1, tag: 4'd10, value: 32'h2100};
    send_op(OP_LW, 4'd3, 4'd10, '0, '0, '0, 32'd4);
    broadcast(4'd9, 32'h2000);
    collect_results();
    report_test();
  endtask

  task automatic store_ordering();
    int    reads_before;
    int    writes_before;
    line_t exp_line;
    start_test("store_ordering");
    reads_before = mem_reads;
    writes_before = mem_writes;
    issue_store(OP_SW, 4'd4, 32'h3040, 32'hcafe_f00d);
    issue_load(OP_LW, 4'd5, 32'h3040, 32'd0);
    idle_cycles(20);
    check_value("results before commit", '0, word_t'(got_order.size()));
    check_value("memory reads before commit", word_t'(reads_before), word_t'(mem_reads));
    pulse_commit();
    issue_store(OP_SB, 4'd6, 32'h3045, 32'h0000_0077);
    issue_load(OP_LW, 4'd7, 32'h3044, 32'd0);
    pulse_commit();
    // same set, other tag, so the dirty line goes back
    issue_load(OP_LW, 4'd8, 32'h3140, 32'd0);
    collect_results();
    for (int k = 0; k < 16; k++) begin
      exp_line[k*8 +: 8] = mem_byte(32'h3040 + word_t'(k));
    end
    check_value("writeback count", word_t'(writes_before + 1), word_t'(mem_writes));
    check_value("writeback address", 32'h3040, last_wr_addr);
    for (int w = 0; w < 4; w++) begin
      check_value($sformatf("writeback word %0d", w), exp_line[w*32 +: 32],
                  last_wr_line[w*32 +: 32]);
    end
    report_test();
  endtask

  task automatic io_access();
    int io_before;
    start_test("io_access");
    issue_load(OP_LB, 4'd9, IO_BASE, 32'd5);
    io_before = io_writes;
    issue_store(OP_SB, 4'd10, IO_BASE + 32'h12, 32'h0000_003c);
    idle_cycles(20);
    check_value("io writes before commit", word_t'(io_before), word_t'(io_writes));
    pulse_commit();
    while (io_writes == io_before) idle_cycles(1);
    check_value("io write address", IO_BASE + 32'h12, last_io_addr);
    check_value("io write data", 32'h3c, word_t'(last_io_data));
    collect_results();
    report_test();
  endtask

  task automatic flush_and_full();
    int issued;
    start_test("flush_and_full");
    issued = 0;
    // base tag 15 is never broadcast before the flush
    while (!full) begin
      send_op(OP_LW, rob_id_t'(issued + 1), 4'd15, '0, '0, '0, '0);
      flushed_tags[issued + 1] = 1'b1;
      issued++;
    end
    check_value("ops accepted before full", word_t'(QUEUE_DEPTH - 1), word_t'(issued));
    flush = 1'b1;
    idle_cycles(1);
    flush = 1'b0;
    check_value("full after flush", '0, word_t'(full));
    broadcast(4'd15, 32'h1000);
    idle_cycles(10);
    issue_load(OP_LW, 4'd11, 32'h1084, 32'd0);
    issue_load(OP_LBU, 4'd12, 32'h2488, 32'd1);
    issue_load(OP_LH, 4'd13, 32'h1090, 32'd2);
    collect_results();
    flushed_tags = '0;
    report_test();
  endtask

  initial begin
    repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'hbc00));
    rst = 1'b1;
    issue = '0;
    rs_cdb = '0;
    commit_store = 1'b0;
    flush = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    load_widths();
    operand_wakeup();
    store_ordering();
    io_access();
    flush_and_full();
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/lsu_properties.sv ====
`default_nettype none

module lsu_properties (
  input wire logic              clk,
  input wire logic              rst,
  input wire logic              done,
  input wire lsu_pkg::mem_req_t mem_req,
  input wire logic              mem_ready,
  input wire lsu_pkg::io_req_t  io_req,
  input wire logic              io_ready
);

  // request fields hold until the ready cycle
  mem_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req.valid && !mem_ready |=> $stable(mem_req))
    else $error("mem_req changed while waiting for mem_ready");

  io_req_stable: assert property (@(posedge clk) disable iff (rst)
    io_req.valid && !io_ready |=> $stable(io_req))
    else $error("io_req changed while waiting for io_ready");

  ports_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(mem_req.valid && io_req.valid))
    else $error("mem_req and io_req valid at the same time");

  // an i/o access finishes exactly once
  io_done_once: assert property (@(posedge clk) disable iff (rst)
    done && io_req.valid |=> !(done && io_req.valid))
    else $error("done held for two cycles on an i/o access");

endmodule

bind data_cache lsu_properties lsu_properties_i (
  .clk(clk),
  .rst(rst),
  .done(done),
  .mem_req(mem_req),
  .mem_ready(mem_ready),
  .io_req(io_req),
  .io_ready(io_ready)
);

`default_nettype wire

// ==== verification/mem_model.sv ====
`default_nettype none

module mem_model (
  input  wire logic              clk,
  input  wire lsu_pkg::mem_req_t mem_req,
  output logic                   mem_ready,
  output lsu_pkg::line_t         mem_rdata,
  input  wire lsu_pkg::io_req_t  io_req,
  output logic                   io_ready,
  output lsu_pkg::byte_t         io_rdata,
  output int                     mem_reads,
  output int                     mem_writes,
  output int                     io_writes,
  output lsu_pkg::word_t         last_wr_addr,
  output lsu_pkg::line_t         last_wr_line,
  output lsu_pkg::word_t         last_io_addr,
  output lsu_pkg::byte_t         last_io_data
);
  import lsu_pkg::*;

  // lines written back, keyed by line address
  line_t written [word_t];

  // untouched bytes follow the fill pattern
  function automatic line_t line_at(input word_t addr);
    line_t l;
    word_t a;
    if (written.exists(addr)) return written[addr];
    for (int k = 0; k < 16; k++) begin
      a = addr + word_t'(k);
      l[k*8 +: 8] = a[7:0] ^ 8'h5a;
    end
    return l;
  endfunction

  initial begin : line_port
    int unsigned delay;
    mem_ready = 1'b0;
    mem_rdata = '0;
    mem_reads = 0;
    mem_writes = 0;
    last_wr_addr = '0;
    last_wr_line = '0;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req.valid) begin
        delay = $urandom_range(6, 1);
        repeat (delay - 1) begin
          @(posedge clk);
          #1;
        end
        if (mem_req.write) begin
          written[mem_req.addr] = mem_req.line;
          mem_writes++;
          last_wr_addr = mem_req.addr;
          last_wr_line = mem_req.line;
        end else begin
          mem_rdata = line_at(mem_req.addr);
          mem_reads++;
        end
        mem_ready = 1'b1;
        @(posedge clk);
        #1;
        mem_ready = 1'b0;
      end
    end
  end

  initial begin : io_port
    int unsigned delay;
    io_ready = 1'b0;
    io_rdata = '0;
    io_writes = 0;
    last_io_addr = '0;
    last_io_data = '0;
    forever begin
      @(posedge clk);
      #1;
      if (io_req.valid) begin
        delay = $urandom_range(6, 1);
        repeat (delay - 1) begin
          @(posedge clk);
          #1;
        end
        if (io_req.write) begin
          io_writes++;
          last_io_addr = io_req.addr;
          last_io_data = io_req.data;
        end else begin
          // device register value
          io_rdata = 8'h80 + byte_t'(io_req.addr[3:0]);
        end
        io_ready = 1'b1;
        @(posedge clk);
        #1;
        io_ready = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`default_nettype none

module lsu_top #(
  parameter int QUEUE_DEPTH = 8,
  parameter int CACHE_LINES = 16
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire lsu_pkg::issue_t issue,
  output logic                 full,
  input  wire lsu_pkg::cdb_t   rs_cdb,
  input  wire logic            commit_store,
  input  wire logic            flush,
  output lsu_pkg::mem_req_t    mem_req,
  input  wire logic            mem_ready,
  input  wire lsu_pkg::line_t  mem_rdata,
  output lsu_pkg::io_req_t     io_req,
  input  wire logic            io_ready,
  input  wire lsu_pkg::byte_t  io_rdata,
  output lsu_pkg::cdb_t        ls_cdb
);
  import lsu_pkg::*;

  logic      head_valid;
  ls_req_t   head;
  logic      done;
  load_raw_t load_raw;

  // own results wake waiting entries too
  ls_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) ls_queue_i (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .commit_store(commit_store),
    .issue(issue),
    .rs_cdb(rs_cdb),
    .ls_cdb(ls_cdb),
    .done(done),
    .full(full),
    .head_valid(head_valid),
    .head(head)
  );

  data_cache #(
    .CACHE_LINES(CACHE_LINES)
  ) data_cache_i (
    .clk(clk),
    .rst(rst),
    .head_valid(head_valid),
    .head(head),
    .done(done),
    .load_raw(load_raw),
    .mem_req(mem_req),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .io_req(io_req),
    .io_ready(io_ready),
    .io_rdata(io_rdata)
  );

  load_align load_align_i (
    .clk(clk),
    .rst(rst),
    .load_raw(load_raw),
    .ls_cdb(ls_cdb)
  );

endmodule

`default_nettype wire

// ==== verilog/load_align.sv ====
`default_nettype none

module load_align (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire lsu_pkg::load_raw_t load_raw,
  output lsu_pkg::cdb_t           ls_cdb
);
  import lsu_pkg::*;

  word_t window;
  word_t value;

  // little-endian, lowest byte at the offset
  assign window = word_t'(load_raw.line >> {load_raw.offset, 3'b000});

  always_comb begin
    case (load_raw.op)
      OP_LB:   value = {{24{window[7]}}, window[7:0]};
      OP_LBU:  value = {24'b0, window[7:0]};
      OP_LH:   value = {{16{window[15]}}, window[15:0]};
      OP_LHU:  value = {16'b0, window[15:0]};
      default: value = window;
    endcase
  end

  always_ff @(posedge clk) begin
    ls_cdb.tag <= load_raw.dest;
    ls_cdb.value <= value;
    if (rst) begin
      ls_cdb.valid <= 1'b0;
    end else begin
      ls_cdb.valid <= load_raw.valid;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/data_cache.sv ====
`default_nettype none

module data_cache #(
  parameter int CACHE_LINES = 16
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             head_valid,
  input  wire lsu_pkg::ls_req_t head,
  output logic                  done,
  output lsu_pkg::load_raw_t    load_raw,
  output lsu_pkg::mem_req_t     mem_req,
  input  wire logic             mem_ready,
  input  wire lsu_pkg::line_t   mem_rdata,
  output lsu_pkg::io_req_t      io_req,
  input  wire logic             io_ready,
  input  wire lsu_pkg::byte_t   io_rdata
);
  import lsu_pkg::*;

  localparam int INDEX_BITS = $clog2(CACHE_LINES);
  localparam int TAG_BITS = 32 - LINE_OFFSET_BITS - INDEX_BITS;

  typedef enum logic [2:0] {IDLE, REFILL, WRITEBACK, IO_READ, IO_WRITE} state_t;

  state_t state;
  line_t lines [CACHE_LINES];
  logic [TAG_BITS-1:0] tags [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_bits;
  logic [CACHE_LINES-1:0] dirty_bits;

  logic [INDEX_BITS-1:0] head_index;
  logic [TAG_BITS-1:0]   head_tag;
  offset_t               head_offset;
  logic [INDEX_BITS-1:0] fill_index;
  logic [TAG_BITS-1:0]   fill_tag;
  logic head_store;
  logic head_io;
  logic hit;
  logic hit_go;
  logic miss_go;
  line_t store_line;

  function automatic line_t merge(input line_t l, input offset_t off, input ls_op_t op,
                                  input word_t d);
    line_t r;
    int n;
    offset_t pos;
    r = l;
    case (op)
      OP_SB: n = 1;
      OP_SH: n = 2;
      default: n = 4;
    endcase
    for (int k = 0; k < 4; k++) begin
      pos = off + offset_t'(k);
      if (k < n) r[{pos, 3'b000} +: 8] = d[k*8 +: 8];
    end
    return r;
  endfunction

  assign head_index = head.addr[LINE_OFFSET_BITS +: INDEX_BITS];
  assign head_tag = head.addr[31 -: TAG_BITS];
  assign head_offset = head.addr[LINE_OFFSET_BITS-1:0];
  // refill address stays put even if the queue flushes
  assign fill_index = mem_req.addr[LINE_OFFSET_BITS +: INDEX_BITS];
  assign fill_tag = mem_req.addr[31 -: TAG_BITS];

  assign head_store = head.op >= OP_SB;
  assign head_io = head.addr >= IO_BASE;
  assign hit = valid_bits[head_index] && tags[head_index] == head_tag;
  assign hit_go = state == IDLE && head_valid && !head_io && hit;
  assign miss_go = state == IDLE && head_valid && !head_io && !hit;
  assign store_line = merge(lines[head_index], head_offset, head.op, head.data);

  assign done = hit_go || ((state == IO_READ || state == IO_WRITE) && io_ready);

  always_comb begin
    load_raw.valid = (hit_go && !head_store) || (state == IO_READ && io_ready);
    load_raw.op = head.op;
    load_raw.dest = head.dest;
    // io byte sits at offset 0
    load_raw.offset = (state == IO_READ) ? '0 : head_offset;
    load_raw.line = (state == IO_READ) ? line_t'(io_rdata) : lines[head_index];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      mem_req.valid <= 1'b0;
      io_req.valid <= 1'b0;
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (head_valid && head_io) begin
            io_req <= '{valid: 1'b1, write: head_store, addr: head.addr,
                        data: head.data[7:0]};
            state <= head_store ? IO_WRITE : IO_READ;
          end else if (hit_go && head_store) begin
            dirty_bits[head_index] <= 1'b1;
          end else if (miss_go) begin
            mem_req <= '{valid: 1'b1, write: 1'b0,
                         addr: {head.addr[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}},
                         line: lines[head_index]};
            state <= REFILL;
          end
        end
        REFILL: begin
          if (mem_ready) begin
            valid_bits[fill_index] <= 1'b1;
            dirty_bits[fill_index] <= 1'b0;
            if (dirty_bits[fill_index]) begin
              // old tag and data still in the arrays this cycle
              mem_req <= '{valid: 1'b0, write: 1'b1,
                           addr: {tags[fill_index], fill_index, {LINE_OFFSET_BITS{1'b0}}},
                           line: lines[fill_index]};
              state <= WRITEBACK;
            end else begin
              mem_req.valid <= 1'b0;
              state <= IDLE;
            end
          end
        end
        WRITEBACK: begin
          if (!mem_req.valid) begin
            mem_req.valid <= 1'b1;
          end else if (mem_ready) begin
            mem_req.valid <= 1'b0;
            state <= IDLE;
          end
        end
        IO_READ, IO_WRITE: begin
          if (io_ready) begin
            io_req.valid <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (hit_go && head_store) lines[head_index] <= store_line;
    if (state == REFILL && mem_ready) begin
      lines[fill_index] <= mem_rdata;
      tags[fill_index] <= fill_tag;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ls_queue.sv ====
`default_nettype none

module ls_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            flush,
  input  wire logic            commit_store,
  input  wire lsu_pkg::issue_t issue,
  input  wire lsu_pkg::cdb_t   rs_cdb,
  input  wire lsu_pkg::cdb_t   ls_cdb,
  input  wire logic            done,
  output logic                 full,
  output logic                 head_valid,
  output lsu_pkg::ls_req_t     head
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [QUEUE_DEPTH-1:0] busy;
  logic [QUEUE_DEPTH-1:0] addr_ready;
  ls_op_t  op [QUEUE_DEPTH];
  rob_id_t dest [QUEUE_DEPTH];
  rob_id_t qj [QUEUE_DEPTH];
  rob_id_t qk [QUEUE_DEPTH];
  word_t   vj [QUEUE_DEPTH];
  word_t   vk [QUEUE_DEPTH];
  word_t   imm [QUEUE_DEPTH];

  rob_id_t woke_qj [QUEUE_DEPTH];
  rob_id_t woke_qk [QUEUE_DEPTH];
  word_t   woke_vj [QUEUE_DEPTH];
  word_t   woke_vk [QUEUE_DEPTH];

  logic [IDX_W-1:0] head_ptr;
  logic [IDX_W-1:0] tail_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] commit_cnt;

  logic [IDX_W-1:0] calc_idx;
  logic             calc_valid;
  rob_id_t          iss_qj;
  rob_id_t          iss_qk;
  word_t            iss_vj;
  word_t            iss_vk;
  logic             head_store;
  logic             pop;

  function automatic logic [IDX_W-1:0] bump(input logic [IDX_W-1:0] p);
    return (p == IDX_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // capture a pending operand from either result bus
  function automatic void wake(input cdb_t bus_a, input cdb_t bus_b,
                               inout rob_id_t q, inout word_t v);
    if (q != '0 && bus_a.valid && bus_a.tag == q) begin
      v = bus_a.value;
      q = '0;
    end else if (q != '0 && bus_b.valid && bus_b.tag == q) begin
      v = bus_b.value;
      q = '0;
    end
  endfunction

  always_comb begin
    iss_qj = issue.qj;
    iss_vj = issue.vj;
    iss_qk = issue.qk;
    iss_vk = issue.vk;
    wake(rs_cdb, ls_cdb, iss_qj, iss_vj);
    wake(rs_cdb, ls_cdb, iss_qk, iss_vk);
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      woke_qj[i] = qj[i];
      woke_vj[i] = vj[i];
      woke_qk[i] = qk[i];
      woke_vk[i] = vk[i];
      wake(rs_cdb, ls_cdb, woke_qj[i], woke_vj[i]);
      wake(rs_cdb, ls_cdb, woke_qk[i], woke_vk[i]);
    end
  end

  // lowest index wins
  always_comb begin
    calc_valid = 1'b0;
    calc_idx = '0;
    for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
      if (busy[i] && !addr_ready[i] && qj[i] == '0) begin
        calc_valid = 1'b1;
        calc_idx = IDX_W'(i);
      end
    end
  end

  assign head_store = op[head_ptr] >= OP_SB;
  assign head_valid = busy[head_ptr] && qj[head_ptr] == '0 && addr_ready[head_ptr] &&
                      (!head_store ||
                       (qk[head_ptr] == '0 && (commit_cnt != '0 || commit_store)));
  assign head = '{op: op[head_ptr], addr: vj[head_ptr], data: vk[head_ptr],
                  dest: dest[head_ptr]};
  assign full = count >= CNT_W'(QUEUE_DEPTH - 1);
  assign pop = done && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
      head_ptr <= '0;
      tail_ptr <= '0;
      count <= '0;
      commit_cnt <= '0;
    end else begin
      // commit count survives a flush
      commit_cnt <= commit_cnt + CNT_W'(commit_store) - CNT_W'(done && head_store);
      if (flush) begin
        busy <= '0;
        head_ptr <= '0;
        tail_ptr <= '0;
        count <= '0;
      end else begin
        if (pop) begin
          busy[head_ptr] <= 1'b0;
          head_ptr <= bump(head_ptr);
        end
        if (issue.valid) begin
          busy[tail_ptr] <= 1'b1;
          tail_ptr <= bump(tail_ptr);
        end
        count <= count + CNT_W'(issue.valid) - CNT_W'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      qj[i] <= woke_qj[i];
      vj[i] <= woke_vj[i];
      qk[i] <= woke_qk[i];
      vk[i] <= woke_vk[i];
    end
    // base becomes the address
    if (calc_valid) begin
      vj[calc_idx] <= vj[calc_idx] + imm[calc_idx];
      addr_ready[calc_idx] <= 1'b1;
    end
    if (issue.valid) begin
      op[tail_ptr] <= issue.op;
      dest[tail_ptr] <= issue.dest;
      qj[tail_ptr] <= iss_qj;
      vj[tail_ptr] <= iss_vj;
      qk[tail_ptr] <= iss_qk;
      vk[tail_ptr] <= iss_vk;
      imm[tail_ptr] <= issue.imm;
      addr_ready[tail_ptr] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  localparam int LINE_OFFSET_BITS = 4;
  localparam logic [31:0] IO_BASE = 32'h0003_0000;

  typedef logic [31:0] word_t;
  typedef logic [3:0] rob_id_t;
  typedef logic [7:0] byte_t;
  typedef logic [127:0] line_t;
  typedef logic [LINE_OFFSET_BITS-1:0] offset_t;

  // stores follow all loads, so op >= OP_SB means store
  typedef enum logic [2:0] {
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW
  } ls_op_t;

  typedef struct packed {
    logic valid;
    ls_op_t op;
    rob_id_t dest;
    rob_id_t qj;
    word_t vj;
    rob_id_t qk;
    word_t vk;
    word_t imm;
  } issue_t;

  typedef struct packed {
    logic valid;
    rob_id_t tag;
    word_t value;
  } cdb_t;

  typedef struct packed {
    ls_op_t op;
    word_t addr;
    word_t data;
    rob_id_t dest;
  } ls_req_t;

  typedef struct packed {
    logic valid;
    logic write;
    word_t addr;
    line_t line;
  } mem_req_t;

  typedef struct packed {
    logic valid;
    logic write;
    word_t addr;
    byte_t data;
  } io_req_t;

  typedef struct packed {
    logic valid;
    ls_op_t op;
    offset_t offset;
    rob_id_t dest;
    line_t line;
  } load_raw_t;

endpackage

`default_nettype wire
